// File: hw/mesh_pkg.sv
// Mesh packet format
// Field widths and the packed transaction word carried by both
// crossings of the link
package mesh_pkg;

  // Field widths
  localparam int DATAMODE_W = 2;
  localparam int CTRLMODE_W = 5;
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;

  // One mesh transaction
  // Declared from the top bit down, so write lands in bit 0
  typedef struct packed {
    // Return address for read responses
    logic [ADDR_W-1:0]     srcaddr;
    // Write data, or read data on a response
    logic [DATA_W-1:0]     data;
    // Target address
    logic [ADDR_W-1:0]     dstaddr;
    // Transaction modifiers, passed through untouched
    logic [CTRLMODE_W-1:0] ctrlmode;
    // Access size code
    logic [DATAMODE_W-1:0] datamode;
    // High for a write, low for a read
    logic                  write;
  } mesh_packet_t;

  // Flat width of one packet, 104 bits
  localparam int PACKET_W = $bits(mesh_packet_t);

endpackage

// File: hw/gray_pkg.sv
// Pointer crossing helpers
// Synchronizer depth and binary/Gray conversion for FIFO pointers
package gray_pkg;

  // Flops in each pointer synchronizer
  localparam int SYNC_STAGES = 2;

  // Widest pointer the conversions handle, callers zero-extend
  localparam int CODE_W = 32;

  // Binary to reflected Gray
  function automatic logic [CODE_W-1:0] bin2gray(input logic [CODE_W-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // Gray back to binary, running XOR from the top bit down
  function automatic logic [CODE_W-1:0] gray2bin(input logic [CODE_W-1:0] gray);
    logic [CODE_W-1:0] bin;
    bin[CODE_W-1] = gray[CODE_W-1];
    for (int i = CODE_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// File: hw/fifo_wr_ctrl.sv
// Async FIFO write controller
// Write pointer in binary and Gray, read pointer synchronizer,
// registered full flag
module fifo_wr_ctrl #(
  parameter int DEPTH_LOG2 = 4
) (
  input  logic                  wr_clk,
  input  logic                  reset,
  input  logic                  wr_en,
  input  logic [DEPTH_LOG2:0]   rd_gray,
  output logic [DEPTH_LOG2-1:0] wr_addr,
  output logic [DEPTH_LOG2:0]   wr_gray,
  output logic                  full
);

  // One extra pointer bit tells full from empty
  localparam int PTR_W = DEPTH_LOG2 + 1;
  localparam int PAD_W = gray_pkg::CODE_W - PTR_W;

  logic                                        push;
  logic [PTR_W-1:0]                            wr_bin;
  logic [PTR_W-1:0]                            wr_bin_next;
  logic [PTR_W-1:0]                            rq_bin;
  logic [gray_pkg::SYNC_STAGES-1:0][PTR_W-1:0] rd_sync;
  logic [gray_pkg::CODE_W-1:0]                 gray_wide;
  logic [gray_pkg::CODE_W-1:0]                 bin_wide;

  // Writes while full are dropped
  assign push = wr_en & ~full;

  always_comb begin
    wr_bin_next = wr_bin + {{DEPTH_LOG2{1'b0}}, push};
    gray_wide   = gray_pkg::bin2gray({{PAD_W{1'b0}}, wr_bin_next});
    // Synchronized read pointer back in binary
    bin_wide    = gray_pkg::gray2bin({{PAD_W{1'b0}}, rd_sync[gray_pkg::SYNC_STAGES-1]});
    rq_bin      = bin_wide[PTR_W-1:0];
  end

  always_ff @(posedge wr_clk or posedge reset) begin
    if (reset) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      rd_sync <= '0;
      full    <= 1'b0;
    end else begin
      wr_bin  <= wr_bin_next;
      wr_gray <= gray_wide[PTR_W-1:0];
      // Stage 0 samples the foreign pointer
      rd_sync <= {rd_sync[gray_pkg::SYNC_STAGES-2:0], rd_gray};
      // Full when next pointer is one lap ahead of the read pointer
      full    <= (wr_bin_next[DEPTH_LOG2] != rq_bin[DEPTH_LOG2]) &&
                 (wr_bin_next[DEPTH_LOG2-1:0] == rq_bin[DEPTH_LOG2-1:0]);
    end
  end

  assign wr_addr = wr_bin[DEPTH_LOG2-1:0];

endmodule

// File: hw/fifo_rd_ctrl.sv
// Async FIFO read controller
// Read pointer in binary and Gray, write pointer synchronizer,
// registered empty flag
module fifo_rd_ctrl #(
  parameter int DEPTH_LOG2 = 4
) (
  input  logic                  rd_clk,
  input  logic                  reset,
  input  logic                  rd_en,
  input  logic [DEPTH_LOG2:0]   wr_gray,
  output logic [DEPTH_LOG2-1:0] rd_addr,
  output logic [DEPTH_LOG2:0]   rd_gray,
  output logic                  empty
);

  // Same pointer width as the write side
  localparam int PTR_W = DEPTH_LOG2 + 1;
  localparam int PAD_W = gray_pkg::CODE_W - PTR_W;

  logic                                        pop;
  logic [PTR_W-1:0]                            rd_bin;
  logic [PTR_W-1:0]                            rd_bin_next;
  logic [PTR_W-1:0]                            wq_bin;
  logic [gray_pkg::SYNC_STAGES-1:0][PTR_W-1:0] wr_sync;
  logic [gray_pkg::CODE_W-1:0]                 gray_wide;
  logic [gray_pkg::CODE_W-1:0]                 bin_wide;

  // Reads while empty are ignored
  assign pop = rd_en & ~empty;

  always_comb begin
    rd_bin_next = rd_bin + {{DEPTH_LOG2{1'b0}}, pop};
    gray_wide   = gray_pkg::bin2gray({{PAD_W{1'b0}}, rd_bin_next});
    // Synchronized write pointer back in binary
    bin_wide    = gray_pkg::gray2bin({{PAD_W{1'b0}}, wr_sync[gray_pkg::SYNC_STAGES-1]});
    wq_bin      = bin_wide[PTR_W-1:0];
  end

  always_ff @(posedge rd_clk or posedge reset) begin
    if (reset) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      wr_sync <= '0;
      empty   <= 1'b1;
    end else begin
      rd_bin  <= rd_bin_next;
      rd_gray <= gray_wide[PTR_W-1:0];
      // Stage 0 samples the foreign pointer
      wr_sync <= {wr_sync[gray_pkg::SYNC_STAGES-2:0], wr_gray};
      // Empty once the next pointer catches the write pointer
      empty   <= (rd_bin_next == wq_bin);
    end
  end

  assign rd_addr = rd_bin[DEPTH_LOG2-1:0];

endmodule

// File: hw/fifo_async.sv
// Dual-clock FIFO
// Gray pointer crossing around a 2^DEPTH_LOG2 entry memory, with a
// registered first-word-fall-through output stage on the read clock
module fifo_async #(
  parameter int DW         = 104,
  parameter int DEPTH_LOG2 = 4
) (
  input  logic          wr_clk,
  input  logic          rd_clk,
  input  logic          reset,
  input  logic          wr_en,
  input  logic [DW-1:0] din,
  output logic          full,
  input  logic          rd_en,
  output logic [DW-1:0] dout,
  output logic          valid
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  logic [DW-1:0]         mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_addr;
  logic [DEPTH_LOG2-1:0] rd_addr;
  logic [DEPTH_LOG2:0]   wr_gray;
  logic [DEPTH_LOG2:0]   rd_gray;
  logic                  empty;
  logic                  push;
  logic                  mem_rd;

  fifo_wr_ctrl #(.DEPTH_LOG2(DEPTH_LOG2)) i_wr_ctrl (
    .wr_clk  (wr_clk),
    .reset   (reset),
    .wr_en   (wr_en),
    .rd_gray (rd_gray),
    .wr_addr (wr_addr),
    .wr_gray (wr_gray),
    .full    (full)
  );

  fifo_rd_ctrl #(.DEPTH_LOG2(DEPTH_LOG2)) i_rd_ctrl (
    .rd_clk  (rd_clk),
    .reset   (reset),
    .rd_en   (mem_rd),
    .wr_gray (wr_gray),
    .rd_addr (rd_addr),
    .rd_gray (rd_gray),
    .empty   (empty)
  );

  // Write port
  assign push = wr_en & ~full;

  always_ff @(posedge wr_clk) begin
    if (push) begin
      mem[wr_addr] <= din;
    end
  end

  // Refill output stage when it is free or being emptied this cycle
  assign mem_rd = ~empty & (~valid | rd_en);

  always_ff @(posedge rd_clk) begin
    if (mem_rd) begin
      dout <= mem[rd_addr];
    end
  end

  // Output stage occupancy
  always_ff @(posedge rd_clk or posedge reset) begin
    if (reset) begin
      valid <= 1'b0;
    end else if (mem_rd) begin
      valid <= 1'b1;
    end else if (rd_en) begin
      valid <= 1'b0;
    end
  end

endmodule

// File: hw/fifo_cdc.sv
// Clock domain crossing with access/wait flow control
// Accepts packets on wr_clk while not full, presents them on rd_clk
// and holds each one until the receiver drops wait
module fifo_cdc #(
  parameter int DW         = 104,
  parameter int DEPTH_LOG2 = 4
) (
  input  logic          wr_clk,
  input  logic          rd_clk,
  input  logic          reset,
  input  logic          access_in,
  input  logic [DW-1:0] packet_in,
  output logic          wait_out,
  output logic          access_out,
  output logic [DW-1:0] packet_out,
  input  logic          wait_in
);

  logic wr_en;
  logic rd_en;
  logic full;
  logic valid;

  // Sender side, a word is taken when access meets no wait
  assign wr_en    = access_in & ~full;
  assign wait_out = full;

  // Receiver side, pop only on acknowledge
  assign rd_en      = valid & ~wait_in;
  // Output stage is registered, so access_out is a flop
  assign access_out = valid;

  fifo_async #(
    .DW         (DW),
    .DEPTH_LOG2 (DEPTH_LOG2)
  ) i_fifo (
    .wr_clk (wr_clk),
    .rd_clk (rd_clk),
    .reset  (reset),
    .wr_en  (wr_en),
    .din    (packet_in),
    .full   (full),
    .rd_en  (rd_en),
    .dout   (packet_out),
    .valid  (valid)
  );

endmodule

// File: hw/mesh_cdc_link.sv
// Mesh link clock crossing
// Request path from clk_in to clk_out, response path back from
// clk_out to clk_in, both with access/wait flow control
module mesh_cdc_link #(
  parameter int DEPTH_LOG2 = 4
) (
  input  logic                   clk_in,
  input  logic                   clk_out,
  input  logic                   reset,
  // Request, written on clk_in
  input  logic                   req_access_in,
  input  mesh_pkg::mesh_packet_t req_packet_in,
  output logic                   req_wait_out,
  // Request, read on clk_out
  output logic                   req_access_out,
  output mesh_pkg::mesh_packet_t req_packet_out,
  input  logic                   req_wait_in,
  // Response, written on clk_out
  input  logic                   rsp_access_in,
  input  mesh_pkg::mesh_packet_t rsp_packet_in,
  output logic                   rsp_wait_out,
  // Response, read on clk_in
  output logic                   rsp_access_out,
  output mesh_pkg::mesh_packet_t rsp_packet_out,
  input  logic                   rsp_wait_in
);

  // FIFO carries the packet as a flat word
  localparam int DW = mesh_pkg::PACKET_W;

  // Request crossing
  fifo_cdc #(.DW(DW), .DEPTH_LOG2(DEPTH_LOG2)) i_req_cdc (
    .wr_clk     (clk_in),
    .rd_clk     (clk_out),
    .reset      (reset),
    .access_in  (req_access_in),
    .packet_in  (req_packet_in),
    .wait_out   (req_wait_out),
    .access_out (req_access_out),
    .packet_out (req_packet_out),
    .wait_in    (req_wait_in)
  );

  // Response crossing, clocks swapped
  fifo_cdc #(.DW(DW), .DEPTH_LOG2(DEPTH_LOG2)) i_rsp_cdc (
    .wr_clk     (clk_out),
    .rd_clk     (clk_in),
    .reset      (reset),
    .access_in  (rsp_access_in),
    .packet_in  (rsp_packet_in),
    .wait_out   (rsp_wait_out),
    .access_out (rsp_access_out),
    .packet_out (rsp_packet_out),
    .wait_in    (rsp_wait_in)
  );

endmodule

// File: tests/tb_clocks.sv
// Testbench clock and reset source
// clk_out at 20 ns and clk_in at 14 ns, unrelated to each other.
// Power-on reset covers 8 clk_out cycles, extra_reset adds later pulses
module tb_clocks (
  input  logic extra_reset,
  output logic clk_in,
  output logic clk_out,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  // Half periods in ns
  localparam int OUT_HALF = 10;
  localparam int IN_HALF  = 7;

  logic por;

  initial begin
    clk_out = 1'b0;
    forever #OUT_HALF clk_out = ~clk_out;
  end

  initial begin
    clk_in = 1'b0;
    forever #IN_HALF clk_in = ~clk_in;
  end

  // Released on a falling clk_out edge
  initial begin
    por = 1'b1;
    repeat (8) @(posedge clk_out);
    @(negedge clk_out);
    por = 1'b0;
  end

  assign reset = por | extra_reset;

endmodule

// File: tests/tb_mesh_cdc_link.sv
// Testbench for the mesh CDC link
// Random traffic on both crossings with receiver stalls, a capacity
// fill of the request path and a reset in mid-traffic, checked by
// queue scoreboards and immediate assertions
module tb_mesh_cdc_link;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH_LOG2    = 4;
  localparam int TRAFFIC_PKTS  = 64;
  localparam int RESET_PKTS    = 40;
  // Memory plus output stage
  localparam int CAP_WORDS     = (1 << DEPTH_LOG2) + 1;
  localparam int MAX_GAP       = 3;
  localparam int MAX_STALL     = 8;
  localparam int SETTLE_CYCLES = 24;
  localparam int IDLE_CYCLES   = 30;
  // Worst clk_out cycles per packet from writer gap plus reader stall
  localparam int PKT_CYCLES    = MAX_GAP + 1 + MAX_STALL;
  localparam int TIMEOUT_CYCLES = (TRAFFIC_PKTS + RESET_PKTS + 2 * CAP_WORDS) * PKT_CYCLES
                                  + SETTLE_CYCLES + 2 * IDLE_CYCLES + 100;

  logic clk_in;
  logic clk_out;
  logic reset;
  logic extra_reset;
  logic req_access_in;
  logic req_wait_out;
  logic req_access_out;
  logic req_wait_in;
  logic rsp_access_in;
  logic rsp_wait_out;
  logic rsp_access_out;
  logic rsp_wait_in;
  mesh_pkg::mesh_packet_t req_packet_in;
  mesh_pkg::mesh_packet_t req_packet_out;
  mesh_pkg::mesh_packet_t rsp_packet_in;
  mesh_pkg::mesh_packet_t rsp_packet_out;

  // Scoreboards with the oldest accepted word first
  mesh_pkg::mesh_packet_t req_q[$];
  mesh_pkg::mesh_packet_t rsp_q[$];
  mesh_pkg::mesh_packet_t req_expect;
  mesh_pkg::mesh_packet_t rsp_expect;
  mesh_pkg::mesh_packet_t req_hold_pkt;
  mesh_pkg::mesh_packet_t rsp_hold_pkt;
  logic        req_hold = 1'b0;
  logic        rsp_hold = 1'b0;
  logic        stall_stop;
  logic        stall_force;
  logic [31:0] lfsr_state = 32'he9bb;
  int          req_accepted = 0;
  int          req_errors = 0;
  int          rsp_errors = 0;
  int          seq_errors = 0;
  int          cycles = 0;

  tb_clocks i_clocks (.extra_reset, .clk_in, .clk_out, .reset);

  mesh_cdc_link #(.DEPTH_LOG2(DEPTH_LOG2)) i_mesh_cdc_link (
    .clk_in, .clk_out, .reset,
    .req_access_in, .req_packet_in, .req_wait_out,
    .req_access_out, .req_packet_out, .req_wait_in,
    .rsp_access_in, .rsp_packet_in, .rsp_wait_out,
    .rsp_access_out, .rsp_packet_out, .rsp_wait_in
  );

  // Fibonacci LFSR with taps 32 22 2 1
  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int width);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < width; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value      = {value[30:0], fb};
    end
    return value;
  endfunction

  function automatic mesh_pkg::mesh_packet_t make_packet();
    mesh_pkg::mesh_packet_t pkt;
    logic [31:0]            bits;
    bits         = rand_bits(1);
    pkt.write    = bits[0];
    bits         = rand_bits(2);
    pkt.datamode = bits[1:0];
    bits         = rand_bits(5);
    pkt.ctrlmode = bits[4:0];
    pkt.dstaddr  = rand_bits(32);
    pkt.data     = rand_bits(32);
    pkt.srcaddr  = rand_bits(32);
    return pkt;
  endfunction

  // All handshake flags low
  task automatic check_idle(input string name);
    logic [3:0] flags;
    flags = {req_access_out, req_wait_out, rsp_access_out, rsp_wait_out};
    assert (flags == 4'b0000) else begin
      seq_errors++;
      $display("error %s: expected %b actual %b", name, 4'b0000, flags);
    end
  endtask

  // Request writer on clk_in
  // wait_out only moves on clk_in rising edges, so the falling edge
  // value is the one the next rising edge sees
  task automatic req_send(input int count);
    logic [31:0] gap;
    logic        stalled;
    @(negedge clk_in);
    for (int i = 0; i < count; i++) begin
      gap = rand_bits(2);
      if (gap != 0) begin
        req_access_in = 1'b0;
        repeat (gap) @(negedge clk_in);
      end
      req_access_in = 1'b1;
      req_packet_in = make_packet();
      do begin
        stalled = req_wait_out;
        @(negedge clk_in);
      end while (stalled);
    end
    req_access_in = 1'b0;
  endtask

  // Response writer on clk_out
  task automatic rsp_send(input int count);
    logic [31:0] gap;
    logic        stalled;
    @(negedge clk_out);
    for (int i = 0; i < count; i++) begin
      gap = rand_bits(2);
      if (gap != 0) begin
        rsp_access_in = 1'b0;
        repeat (gap) @(negedge clk_out);
      end
      rsp_access_in = 1'b1;
      rsp_packet_in = make_packet();
      do begin
        stalled = rsp_wait_out;
        @(negedge clk_out);
      end while (stalled);
    end
    rsp_access_in = 1'b0;
  endtask

  // Random stall bursts of 1 to MAX_STALL cycles on the request reader
  // Held in stall as well while stall_force is high
  task automatic req_stall();
    int left;
    left = 0;
    while (!stall_stop) begin
      @(negedge clk_out);
      if (left == 0 && rand_bits(2) == 32'd0) begin
        left = rand_bits(3) + 1;
      end
      req_wait_in = (left != 0) || stall_force;
      if (left != 0) left--;
    end
    req_wait_in = 1'b0;
  endtask

  // Same for the response reader on clk_in
  task automatic rsp_stall();
    int left;
    left = 0;
    while (!stall_stop) begin
      @(negedge clk_in);
      if (left == 0 && rand_bits(2) == 32'd0) begin
        left = rand_bits(3) + 1;
      end
      rsp_wait_in = (left != 0) || stall_force;
      if (left != 0) left--;
    end
    rsp_wait_in = 1'b0;
  endtask

  task automatic wait_drained();
    while (req_q.size() != 0 || rsp_q.size() != 0) @(negedge clk_out);
  endtask

  // Second reset while both writers are busy
  // Both readers stall first so both crossings are full going in
  task automatic pulse_reset();
    repeat (10) @(negedge clk_out);
    stall_force = 1'b1;
    while (!(req_wait_out && rsp_wait_out)) @(negedge clk_out);
    extra_reset = 1'b1;
    repeat (4) @(negedge clk_out);
    extra_reset = 1'b0;
    stall_force = 1'b0;
    @(negedge clk_out);
    check_idle("reset_mid");
  endtask

  task automatic run_traffic(input int count, input bit with_reset);
    stall_stop = 1'b0;
    fork
      begin
        fork
          req_send(count);
          rsp_send(count);
        join
        wait_drained();
        stall_stop = 1'b1;
      end
      req_stall();
      rsp_stall();
      if (with_reset) pulse_reset();
    join
  endtask

  // Offer words against a stalled reader until wait_out has stayed
  // high long enough for the pointers to settle
  task automatic fill_request();
    int   full_cycles;
    logic stalled;
    full_cycles = 0;
    @(negedge clk_in);
    req_access_in = 1'b1;
    req_packet_in = make_packet();
    while (full_cycles < SETTLE_CYCLES) begin
      stalled = req_wait_out;
      @(negedge clk_in);
      if (stalled) begin
        full_cycles++;
      end else begin
        req_packet_in = make_packet();
      end
    end
    req_access_in = 1'b0;
  endtask

  // Words in flight are lost on reset
  always @(posedge reset) begin
    req_q.delete();
    rsp_q.delete();
  end

  // Request writes and response reads on clk_in
  always @(posedge clk_in) begin
    if (reset) begin
      rsp_hold = 1'b0;
    end else begin
      if (req_access_in && !req_wait_out) begin
        req_q.push_back(req_packet_in);
        req_accepted++;
      end
      if (rsp_access_out && !rsp_wait_in) begin
        assert (rsp_q.size() != 0) else begin
          rsp_errors++;
          $display("Response packet delivered with no accepted write pending");
        end
        if (rsp_q.size() != 0) begin
          rsp_expect = rsp_q.pop_front();
          assert (rsp_packet_out == rsp_expect) else begin
            rsp_errors++;
            $display("error rsp_integrity: expected %h actual %h", rsp_expect, rsp_packet_out);
          end
        end
      end
      // Stalled word stays put
      if (rsp_hold) begin
        assert (rsp_access_out && rsp_packet_out == rsp_hold_pkt) else begin
          rsp_errors++;
          $display("error rsp_hold: expected 1/%h actual %b/%h",
                   rsp_hold_pkt, rsp_access_out, rsp_packet_out);
        end
      end
      rsp_hold     = rsp_access_out && rsp_wait_in;
      rsp_hold_pkt = rsp_packet_out;
    end
  end

  // Response writes and request reads on clk_out
  always @(posedge clk_out) begin
    if (reset) begin
      req_hold = 1'b0;
    end else begin
      if (rsp_access_in && !rsp_wait_out) rsp_q.push_back(rsp_packet_in);
      if (req_access_out && !req_wait_in) begin
        assert (req_q.size() != 0) else begin
          req_errors++;
          $display("Request packet delivered with no accepted write pending");
        end
        if (req_q.size() != 0) begin
          req_expect = req_q.pop_front();
          assert (req_packet_out == req_expect) else begin
            req_errors++;
            $display("error req_integrity: expected %h actual %h", req_expect, req_packet_out);
          end
        end
      end
      if (req_hold) begin
        assert (req_access_out && req_packet_out == req_hold_pkt) else begin
          req_errors++;
          $display("error req_hold: expected 1/%h actual %b/%h",
                   req_hold_pkt, req_access_out, req_packet_out);
        end
      end
      req_hold     = req_access_out && req_wait_in;
      req_hold_pkt = req_packet_out;
    end
  end

  // Run limit
  always @(posedge clk_out) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still busy after %0d clk_out cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    int base;
    int total;
    extra_reset   = 1'b0;
    stall_stop    = 1'b0;
    stall_force   = 1'b0;
    req_access_in = 1'b0;
    req_packet_in = '0;
    req_wait_in   = 1'b0;
    rsp_access_in = 1'b0;
    rsp_packet_in = '0;
    rsp_wait_in   = 1'b0;

    // Power-on state and then a quiet window with no writes
    @(negedge reset);
    @(negedge clk_out);
    check_idle("reset_init");
    repeat (IDLE_CYCLES) @(negedge clk_out);

    // Both crossings at once
    run_traffic(TRAFFIC_PKTS, 1'b0);

    // Capacity of the request crossing
    @(negedge clk_out);
    req_wait_in = 1'b1;
    base = req_accepted;
    fill_request();
    assert (req_accepted - base == CAP_WORDS) else begin
      seq_errors++;
      $display("error capacity: expected %0d actual %0d", CAP_WORDS, req_accepted - base);
    end
    @(negedge clk_out);
    req_wait_in = 1'b0;
    wait_drained();

    // Traffic cut by a reset pulse
    run_traffic(RESET_PKTS, 1'b1);

    // Late duplicates would show up here
    repeat (IDLE_CYCLES) @(negedge clk_out);

    total = req_errors + rsp_errors + seq_errors;
    $display("Error counts: request %0d, response %0d, reset and capacity %0d",
             req_errors, rsp_errors, seq_errors);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: filelist.f
// Packages first, then RTL from the leaves up, then the testbench
hw/mesh_pkg.sv
hw/gray_pkg.sv
hw/fifo_wr_ctrl.sv
hw/fifo_rd_ctrl.sv
hw/fifo_async.sv
hw/fifo_cdc.sv
hw/mesh_cdc_link.sv
tests/tb_clocks.sv
tests/tb_mesh_cdc_link.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the mesh CDC link testbench with Verilator and runs it.
# The result is taken from the pass line in the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_mesh_cdc_link \
  -f filelist.f \
  || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_mesh_cdc_link)"
echo "$sim_out"

echo "$sim_out" | grep -qx "No errors" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }
